/* source/gate_pkg.sv */
package gate_pkg;

	localparam int word_width = 16;
	localparam int frac_bits = 12;   // Q3.12
	localparam int lanes = 16;
	localparam int tree_levels = $clog2(lanes);

	localparam int mat_addr_bits = 5;
	localparam int mat_depth = 1 << mat_addr_bits;
	localparam int vec_addr_bits = 2;
	localparam int vec_depth = 1 << vec_addr_bits;

	// start sample to first out_valid
	localparam int pipe_latency = 6;
	localparam int dp_stages = pipe_latency - 2;   // fetch holds the other two

	localparam logic sel_weight = 1'b0;
	localparam logic sel_vector = 1'b1;

	typedef logic signed [word_width-1:0] word_t;
	typedef word_t [lanes-1:0] row_t;   // lane 0 in the low bits

	typedef struct packed {
		logic en;
		logic sel;
		logic [mat_addr_bits-1:0] addr;   // vector memory takes the low bits
		row_t row;
	} mem_write_t;

	typedef struct packed {
		logic valid;
		logic last;   // final row of the sweep
	} fetch_tag_t;

endpackage

/* source/row_memory.sv */
`timescale 1ns/1ps

module row_memory #(
	parameter type payload_t = logic,
	parameter int addr_bits = 1
) (
	input  logic                 clk,
	input  logic                 wr_en,
	input  logic [addr_bits-1:0] wr_addr,
	input  payload_t             wr_data,
	input  logic [addr_bits-1:0] rd_addr,
	output payload_t             rd_data
);

	payload_t mem [2**addr_bits];

	// same-address read sees the old row
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* source/fixed_mul_lane.sv */
`timescale 1ns/1ps

module fixed_mul_lane (
	input  logic            clk,
	input  gate_pkg::word_t a,
	input  gate_pkg::word_t b,
	output gate_pkg::word_t product
);

	logic [gate_pkg::word_width-1:0] mag_a;
	logic [gate_pkg::word_width-1:0] mag_b;
	logic [2*gate_pkg::word_width-1:0] mag_prod;
	logic [gate_pkg::word_width-1:0] kept;
	logic neg;

	// -32768 keeps magnitude 0x8000
	assign mag_a = a[gate_pkg::word_width-1] ? -a : a;
	assign mag_b = b[gate_pkg::word_width-1] ? -b : b;
	assign neg = a[gate_pkg::word_width-1] ^ b[gate_pkg::word_width-1];

	assign mag_prod = (2*gate_pkg::word_width)'(mag_a) * (2*gate_pkg::word_width)'(mag_b);

	// bits 26..12 with the top bit of the word forced to zero
	assign kept = {1'b0,
		mag_prod[gate_pkg::frac_bits+gate_pkg::word_width-2:gate_pkg::frac_bits]};

	always_ff @(posedge clk) begin
		product <= neg ? -kept : kept;
	end

endmodule

/* source/adder_tree.sv */
`timescale 1ns/1ps

module adder_tree (
	input  logic            clk,
	input  gate_pkg::row_t  terms,
	output gate_pkg::word_t sum
);

	gate_pkg::row_t node;
	gate_pkg::word_t tree_sum;
	gate_pkg::word_t mid_sum;

	// in-place pairwise reduction with one level per outer pass
	always_comb begin
		node = terms;
		for (int l = 1; l <= gate_pkg::tree_levels; l++) begin
			for (int i = 0; i < (gate_pkg::lanes >> l); i++) begin
				node[i] = node[2*i] + node[2*i+1];   // wraps at 16 bits
			end
		end
		tree_sum = node[0];
	end

	// mid-tree stage sits after the last level here
	always_ff @(posedge clk) begin
		mid_sum <= tree_sum;
		sum <= mid_sum;
	end

endmodule

/* source/dot_product_unit.sv */
`timescale 1ns/1ps

module dot_product_unit (
	input  logic            clk,
	input  gate_pkg::row_t  weight_row,
	input  gate_pkg::row_t  input_row,
	output gate_pkg::word_t sum
);

	gate_pkg::row_t weight_q;
	gate_pkg::row_t input_q;
	gate_pkg::row_t prod;

	// operand stage
	always_ff @(posedge clk) begin
		weight_q <= weight_row;
		input_q <= input_row;
	end

	for (genvar i = 0; i < gate_pkg::lanes; i++) begin : g_lane
		fixed_mul_lane u_mul (
			.clk     (clk),
			.a       (input_q[i]),
			.b       (weight_q[i]),
			.product (prod[i])
		);
	end

	adder_tree u_tree (
		.clk   (clk),
		.terms (prod),
		.sum   (sum)
	);

endmodule

/* source/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [gate_pkg::mat_addr_bits-1:0] mat_start,
	input  logic [gate_pkg::mat_addr_bits-1:0] mat_end,
	input  logic [gate_pkg::vec_addr_bits-1:0] vec_start,
	input  logic [gate_pkg::vec_addr_bits-1:0] vec_end,
	input  gate_pkg::mem_write_t               wr,
	output gate_pkg::row_t                     weight_row,
	output gate_pkg::row_t                     input_row,
	output gate_pkg::fetch_tag_t               tag
);

	logic busy;
	logic [gate_pkg::mat_addr_bits-1:0] mat_lo;
	logic [gate_pkg::mat_addr_bits-1:0] mat_hi;
	logic [gate_pkg::vec_addr_bits-1:0] vec_hi;
	logic [gate_pkg::mat_addr_bits-1:0] mat_cnt;
	logic [gate_pkg::vec_addr_bits-1:0] vec_cnt;
	logic [gate_pkg::mat_addr_bits-1:0] mat_rd;
	logic [gate_pkg::vec_addr_bits-1:0] vec_rd;
	logic sweep_last;
	logic weight_we;
	logic vector_we;
	gate_pkg::fetch_tag_t issue_tag;

	assign sweep_last = (mat_cnt == mat_hi) && (vec_cnt == vec_hi);
	assign weight_we = wr.en && !busy && (wr.sel == gate_pkg::sel_weight);
	assign vector_we = wr.en && !busy && (wr.sel == gate_pkg::sel_vector);

	// vector-major walk over the latched window
	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= 1'b0;
			mat_cnt <= '0;
			vec_cnt <= '0;
		end else if (start && !busy) begin
			busy <= 1'b1;
			mat_lo <= mat_start;
			mat_hi <= mat_end;
			vec_hi <= vec_end;
			mat_cnt <= mat_start;
			vec_cnt <= vec_start;
		end else if (busy) begin
			if (mat_cnt == mat_hi) begin
				mat_cnt <= mat_lo;   // back to first row
				if (vec_cnt == vec_hi)
					busy <= 1'b0;
				else
					vec_cnt <= vec_cnt + 1'b1;
			end else begin
				mat_cnt <= mat_cnt + 1'b1;
			end
		end
	end

	// issue stage, then one more register to match read latency
	always_ff @(posedge clk) begin
		mat_rd <= mat_cnt;
		vec_rd <= vec_cnt;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			issue_tag <= '0;
			tag <= '0;
		end else begin
			issue_tag.valid <= busy;
			issue_tag.last <= busy && sweep_last;
			tag <= issue_tag;
		end
	end

	row_memory #(
		.payload_t (gate_pkg::row_t),
		.addr_bits (gate_pkg::mat_addr_bits)
	) u_weight_mem (
		.clk     (clk),
		.wr_en   (weight_we),
		.wr_addr (wr.addr),
		.wr_data (wr.row),
		.rd_addr (mat_rd),
		.rd_data (weight_row)
	);

	row_memory #(
		.payload_t (gate_pkg::row_t),
		.addr_bits (gate_pkg::vec_addr_bits)
	) u_vector_mem (
		.clk     (clk),
		.wr_en   (vector_we),
		.wr_addr (wr.addr[gate_pkg::vec_addr_bits-1:0]),
		.wr_data (wr.row),
		.rd_addr (vec_rd),
		.rd_data (input_row)
	);

	window_order: assert property (@(posedge clk) disable iff (!reset)
		start && !busy |-> (mat_start <= mat_end) && (vec_start <= vec_end));

	no_write_while_busy: assert property (@(posedge clk) disable iff (!reset)
		busy |-> !wr.en);

endmodule

/* source/result_align.sv */
`timescale 1ns/1ps

module result_align (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  gate_pkg::fetch_tag_t tag,
	input  gate_pkg::word_t      sum,
	output gate_pkg::word_t      ht_out,
	output logic                 out_valid,
	output logic                 done
);

	gate_pkg::fetch_tag_t [gate_pkg::dp_stages-1:0] tag_pipe;
	gate_pkg::fetch_tag_t next_out;

	// entry that reaches the output on the coming edge
	assign next_out = tag_pipe[gate_pkg::dp_stages-2];

	always_ff @(posedge clk) begin
		if (!reset) begin
			tag_pipe <= '0;
			done <= 1'b0;
		end else begin
			tag_pipe <= {tag_pipe[gate_pkg::dp_stages-2:0], tag};
			if (next_out.last)
				done <= 1'b1;   // lands with the final out_valid
			else if (start)
				done <= 1'b0;
		end
	end

	assign out_valid = tag_pipe[gate_pkg::dp_stages-1].valid;
	assign ht_out = sum;

	done_with_result: assert property (@(posedge clk) disable iff (!reset)
		$rose(done) |-> out_valid);

endmodule

/* source/gate_top.sv */
`timescale 1ns/1ps

module gate_top (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [gate_pkg::mat_addr_bits-1:0] mat_start,
	input  logic [gate_pkg::mat_addr_bits-1:0] mat_end,
	input  logic [gate_pkg::vec_addr_bits-1:0] vec_start,
	input  logic [gate_pkg::vec_addr_bits-1:0] vec_end,
	input  gate_pkg::mem_write_t               wr,
	output gate_pkg::word_t                    ht_out,
	output logic                               out_valid,
	output logic                               done
);

	gate_pkg::row_t weight_row;
	gate_pkg::row_t input_row;
	gate_pkg::fetch_tag_t fetch_tag;
	gate_pkg::word_t dp_sum;

	operand_fetch u_fetch (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.mat_start  (mat_start),
		.mat_end    (mat_end),
		.vec_start  (vec_start),
		.vec_end    (vec_end),
		.wr         (wr),
		.weight_row (weight_row),
		.input_row  (input_row),
		.tag        (fetch_tag)
	);

	dot_product_unit u_dot (
		.clk        (clk),
		.weight_row (weight_row),
		.input_row  (input_row),
		.sum        (dp_sum)
	);

	result_align u_align (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.tag       (fetch_tag),
		.sum       (dp_sum),
		.ht_out    (ht_out),
		.out_valid (out_valid),
		.done      (done)
	);

endmodule

/* testbench/gate_checker.sv */
`timescale 1ns/1ps

module gate_checker (
	input logic                               clk,
	input logic                               reset,
	input logic                               start,
	input logic [gate_pkg::mat_addr_bits-1:0] mat_start,
	input logic [gate_pkg::mat_addr_bits-1:0] mat_end,
	input logic [gate_pkg::vec_addr_bits-1:0] vec_start,
	input logic [gate_pkg::vec_addr_bits-1:0] vec_end,
	input gate_pkg::mem_write_t               wr,
	input gate_pkg::word_t                    ht_out,
	input logic                               out_valid,
	input logic                               done
);

	typedef struct packed {
		gate_pkg::word_t value;
		int due;   // cycle the result must show up
		logic last;
		logic [7:0] row;
		logic [7:0] vec;
	} expect_t;

	gate_pkg::row_t weight_shadow [gate_pkg::mat_depth];
	gate_pkg::row_t vector_shadow [gate_pkg::vec_depth];
	expect_t pending [$];
	int cyc = 0;
	int busy_left = 0;   // issue cycles left in the running sweep
	logic done_exp = 1'b0;
	int value_errors = 0;
	int timing_errors = 0;
	int done_errors = 0;

	// magnitudes times each other, bits 26..12 kept, sign put back
	function automatic gate_pkg::word_t lane_product(gate_pkg::word_t a, gate_pkg::word_t b);
		int ma;
		int mb;
		longint p;
		int kept;
		ma = (a < 0) ? -int'(a) : int'(a);
		mb = (b < 0) ? -int'(b) : int'(b);
		p = longint'(ma) * longint'(mb);
		kept = int'((p >> gate_pkg::frac_bits) % 32768);
		if ((a < 0) != (b < 0))
			kept = -kept;
		return gate_pkg::word_t'(kept);
	endfunction

	function automatic gate_pkg::word_t row_dot(gate_pkg::row_t w, gate_pkg::row_t x);
		int acc;
		acc = 0;
		for (int l = 0; l < gate_pkg::lanes; l++)
			acc += int'(lane_product(x[l], w[l]));
		return gate_pkg::word_t'(acc);   // low 16 bits, wrapping
	endfunction

	task automatic queue_sweep();
		expect_t e;
		int idx;
		idx = 0;
		for (int v = int'(vec_start); v <= int'(vec_end); v++) begin
			for (int m = int'(mat_start); m <= int'(mat_end); m++) begin
				e.value = row_dot(weight_shadow[m], vector_shadow[v]);
				e.due = cyc + gate_pkg::pipe_latency + idx;
				e.last = (v == int'(vec_end)) && (m == int'(mat_end));
				e.row = 8'(m);
				e.vec = 8'(v);
				pending.push_back(e);
				idx++;
			end
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!reset) begin
			busy_left = 0;
			done_exp = 1'b0;
			pending.delete();
		end else begin
			if (wr.en && busy_left == 0) begin
				if (wr.sel)
					vector_shadow[wr.addr[gate_pkg::vec_addr_bits-1:0]] = wr.row;
				else
					weight_shadow[wr.addr] = wr.row;
			end
			if (start && busy_left == 0) begin
				queue_sweep();
				busy_left = (int'(mat_end) - int'(mat_start) + 1) *
					(int'(vec_end) - int'(vec_start) + 1);
				done_exp = 1'b0;
			end else if (busy_left > 0) begin
				busy_left = busy_left - 1;   // a start here is dropped
			end
		end
	end

	// outputs sampled half a cycle after the edge
	always @(negedge clk) begin
		expect_t e;
		if (reset) begin
			if (out_valid) begin
				if (pending.size() == 0) begin
					$display("unexpected result %h at cycle %0d", ht_out, cyc);
					timing_errors++;
				end else begin
					e = pending.pop_front();
					if (ht_out !== e.value) begin
						$display("error ht_out expected %h actual %h (row %0d, vector %0d)",
							e.value, ht_out, e.row, e.vec);
						value_errors++;
					end
					if (cyc != e.due) begin
						$display("result for row %0d vector %0d came at cycle %0d, not %0d",
							e.row, e.vec, cyc, e.due);
						timing_errors++;
					end
					if (e.last)
						done_exp = 1'b1;
				end
			end else if (pending.size() > 0 && pending[0].due <= cyc) begin
				e = pending.pop_front();
				$display("result for row %0d vector %0d missing at cycle %0d",
					e.row, e.vec, cyc);
				timing_errors++;
			end
			if (done !== done_exp) begin
				$display("error done expected %h actual %h at cycle %0d", done_exp, done, cyc);
				done_errors++;
			end
		end
	end

	task automatic report(input int tb_errors, output int total);
		timing_errors += pending.size();   // never arrived
		total = value_errors + timing_errors + done_errors + tb_errors;
		$display("errors: value %0d, timing %0d, done %0d, sequence %0d",
			value_errors, timing_errors, done_errors, tb_errors);
	endtask

endmodule

/* testbench/tb_gate_top.sv */
`timescale 1ns/1ps

module tb_gate_top;

	typedef struct packed {
		logic [gate_pkg::mat_addr_bits-1:0] mat_start;
		logic [gate_pkg::mat_addr_bits-1:0] mat_end;
		logic [gate_pkg::vec_addr_bits-1:0] vec_start;
		logic [gate_pkg::vec_addr_bits-1:0] vec_end;
		logic [7:0] count;
		logic busy_start;   // second start while running
		logic rewrite;      // fresh rows before this sweep
	} sweep_t;

	localparam int num_sweeps = 8;
	localparam int done_timeout = 200;

	logic clk;
	logic reset;
	logic start;
	logic [gate_pkg::mat_addr_bits-1:0] mat_start;
	logic [gate_pkg::mat_addr_bits-1:0] mat_end;
	logic [gate_pkg::vec_addr_bits-1:0] vec_start;
	logic [gate_pkg::vec_addr_bits-1:0] vec_end;
	gate_pkg::mem_write_t wr;
	gate_pkg::word_t ht_out;
	logic out_valid;
	logic done;

	sweep_t sweeps [num_sweeps];
	integer seed;
	int tb_errors;
	int total_errors;
	bit timed_out;

	gate_top dut (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.mat_start (mat_start),
		.mat_end   (mat_end),
		.vec_start (vec_start),
		.vec_end   (vec_end),
		.wr        (wr),
		.ht_out    (ht_out),
		.out_valid (out_valid),
		.done      (done)
	);

	gate_checker u_check (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.mat_start (mat_start),
		.mat_end   (mat_end),
		.vec_start (vec_start),
		.vec_end   (vec_end),
		.wr        (wr),
		.ht_out    (ht_out),
		.out_valid (out_valid),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic sweep_t make_sweep(int ms, int me, int vs, int ve, int count,
		bit busy_start, bit rewrite);
		sweep_t s;
		s.mat_start = ms[gate_pkg::mat_addr_bits-1:0];
		s.mat_end = me[gate_pkg::mat_addr_bits-1:0];
		s.vec_start = vs[gate_pkg::vec_addr_bits-1:0];
		s.vec_end = ve[gate_pkg::vec_addr_bits-1:0];
		s.count = count[7:0];
		s.busy_start = busy_start;
		s.rewrite = rewrite;
		return s;
	endfunction

	function automatic gate_pkg::row_t random_row();
		gate_pkg::row_t r;
		for (int l = 0; l < gate_pkg::lanes; l++)
			r[l] = gate_pkg::word_t'($random(seed));
		return r;
	endfunction

	task automatic write_row(input logic sel, input int addr, input gate_pkg::row_t row);
		@(posedge clk);
		wr.en <= 1'b1;
		wr.sel <= sel;
		wr.addr <= addr[gate_pkg::mat_addr_bits-1:0];
		wr.row <= row;
	endtask

	task automatic end_writes();
		@(posedge clk);
		wr.en <= 1'b0;
	endtask

	// most negative, -1, 1.0 and full scale in the low lanes
	task automatic load_edge_rows();
		gate_pkg::row_t r;
		r = random_row();
		r[0] = 16'h8000;
		r[1] = 16'hffff;
		r[2] = 16'h1000;
		r[3] = 16'h7fff;
		write_row(gate_pkg::sel_weight, 0, r);
		r = random_row();
		r[0] = 16'h7fff;
		r[1] = 16'h8000;
		r[2] = 16'hffff;
		r[3] = 16'h1000;
		write_row(gate_pkg::sel_vector, 0, r);
		write_row(gate_pkg::sel_weight, 1, {gate_pkg::lanes{16'h7fff}});
		write_row(gate_pkg::sel_vector, 3, {gate_pkg::lanes{16'h8000}});
		end_writes();
	endtask

	task automatic rewrite_rows(input sweep_t s);
		write_row(gate_pkg::sel_weight, int'(s.mat_start), random_row());
		write_row(gate_pkg::sel_weight, int'(s.mat_end), random_row());
		write_row(gate_pkg::sel_vector, int'(s.vec_start), random_row());
		end_writes();
	endtask

	task automatic pulse_start(input sweep_t s);
		@(posedge clk);
		start <= 1'b1;
		mat_start <= s.mat_start;
		mat_end <= s.mat_end;
		vec_start <= s.vec_start;
		vec_end <= s.vec_end;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_sweep(input int n, output bit stuck);
		sweep_t s;
		int results;
		int waited;
		s = sweeps[n];
		results = 0;
		stuck = 1'b0;
		if (s.rewrite)
			rewrite_rows(s);
		pulse_start(s);
		if (s.busy_start) begin
			@(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		for (waited = 0; waited < done_timeout; waited++) begin
			@(negedge clk);
			if (out_valid)
				results++;
			if (done)
				break;
		end
		if (!done) begin
			$display("sweep %0d: done did not rise within %0d cycles", n, done_timeout);
			tb_errors++;
			stuck = 1'b1;
		end else if (results != int'(s.count)) begin
			$display("sweep %0d gave %0d results, table expects %0d", n, results, s.count);
			tb_errors++;
		end
		repeat (3) @(posedge clk);
	endtask

	initial begin
		seed = 32'h96d23b2d;
		reset = 1'b0;
		start = 1'b0;
		mat_start = '0;
		mat_end = '0;
		vec_start = '0;
		vec_end = '0;
		wr = '0;
		tb_errors = 0;
		timed_out = 1'b0;

		sweeps[0] = make_sweep(0, 31, 0, 3, 128, 1'b1, 1'b0);   // whole memory
		sweeps[1] = make_sweep(5, 5, 2, 2, 1, 1'b0, 1'b0);
		sweeps[2] = make_sweep(0, 31, 1, 1, 32, 1'b0, 1'b0);
		sweeps[3] = make_sweep(0, 1, 3, 3, 2, 1'b0, 1'b0);      // full-scale rows
		sweeps[4] = make_sweep(7, 7, 0, 3, 4, 1'b0, 1'b1);
		sweeps[5] = make_sweep(10, 20, 1, 3, 33, 1'b1, 1'b0);
		sweeps[6] = make_sweep(0, 3, 0, 0, 4, 1'b0, 1'b1);
		sweeps[7] = make_sweep(28, 31, 2, 3, 8, 1'b0, 1'b0);

		repeat (16) @(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);

		for (int m = 0; m < gate_pkg::mat_depth; m++)
			write_row(gate_pkg::sel_weight, m, random_row());
		for (int v = 0; v < gate_pkg::vec_depth; v++)
			write_row(gate_pkg::sel_vector, v, random_row());
		load_edge_rows();

		for (int n = 0; n < num_sweeps && !timed_out; n++)
			run_sweep(n, timed_out);

		repeat (4) @(posedge clk);
		u_check.report(tb_errors, total_errors);
		if (total_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* files.f */
source/gate_pkg.sv
source/row_memory.sv
source/fixed_mul_lane.sv
source/adder_tree.sv
source/dot_product_unit.sv
source/operand_fetch.sv
source/result_align.sv
source/gate_top.sv
testbench/gate_checker.sv
testbench/tb_gate_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_gate_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
